/* src.f */
design/icachePkg.sv
design/icacheController.sv
design/icacheTagStore.sv
design/icacheDataStore.sv
design/icacheFillUnit.sv
design/icacheTop.sv
sim/icacheMemModel.sv
sim/icacheTb.sv

/* Makefile */
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP ?= icacheTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

# Pass or fail comes from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/icacheTb.sv */
// Instruction cache testbench with a reference model, response checks and request counts
`timescale 1ns/1ps

module icacheTb import icachePkg::*; ();

  // About 40 fetches, each at most ~50 cycles with long credit delays, doubled
  localparam int FetchCount = 40;
  localparam int WorstMissCycles = 50;
  localparam int CycleLimit = FetchCount * WorstMissCycles * 2;

  logic clk;
  logic reset;
  logic enable;
  logic fetchValid;
  fetchAddr cpuAddr;
  logic creditReturn;
  memBeat beat;
  logic stall;
  logic rspValid;
  logic [DataBits-1:0] rspData;
  logic reqValid;
  memReq req;
  logic longDelay;
  int creditErrors;

  string testName;
  int errorCount = 0;
  int requestCount = 0;
  int respCount = 0;
  int cycleCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errorsAtStart;
  int requestsAtStart;
  logic acceptPending = 1'b0;
  logic [31:0] expWord;

  // Model of the sets, way index 0 is way 1
  logic [TagBits-1:0] modelTag [2][NumSets];
  logic modelValid [2][NumSets];
  logic modelLru [NumSets];

  icacheTop uut (
    .clk(clk), .reset(reset), .enable(enable),
    .fetchValid(fetchValid), .fetchAddr(cpuAddr),
    .creditReturn(creditReturn), .beat(beat),
    .stall(stall), .rspValid(rspValid), .rspData(rspData),
    .reqValid(reqValid), .req(req)
  );

  icacheMemModel memModel (
    .clk(clk), .reset(reset), .longDelay(longDelay),
    .reqValid(reqValid), .req(req),
    .creditReturn(creditReturn), .beat(beat), .creditErrors(creditErrors)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] refWord(input fetchAddr a);
    logic [31:0] wordAddr;
    wordAddr = {2'b00, a.tag, a.index, a.wordOffset};
    return wordAddr * 32'h9e3779b1 + wordAddr;
  endfunction

  // Expected requests for one fetch, updating the set model
  function automatic int predictRequests(input fetchAddr a);
    int way;
    int miss;
    way = 2;
    miss = 0;
    if (!enable) begin
      return 1;
    end
    for (int w = 0; w < 2; w++) begin
      if (modelValid[w][a.index] && modelTag[w][a.index] == a.tag) begin
        way = w;
      end
    end
    if (way == 2) begin
      miss = 1;
      way = ((!modelValid[0][a.index] && modelValid[1][a.index]) || modelLru[a.index]) ? 0 : 1;
      modelValid[way][a.index] = 1'b1;
      modelTag[way][a.index] = a.tag;
    end
    // LRU then points at the way not used
    modelLru[a.index] = (way == 1);
    return miss;
  endfunction

  // Line requests are line aligned, bypass requests name the word itself
  always @(negedge clk) begin
    memReq expReq;
    if (!reset && reqValid) begin
      requestCount++;
      expReq.singleWord = !enable;
      if (enable) begin
        expReq.wordAddr = {cpuAddr.tag, cpuAddr.index, {WordOffsetBits{1'b0}}};
      end else begin
        expReq.wordAddr = {cpuAddr.tag, cpuAddr.index, cpuAddr.wordOffset};
      end
      if (req !== expReq) begin
        $display("ERROR %s memory request expected %08h actual %08h", testName, expReq, req);
        errorCount++;
      end
    end
  end

  // Response must follow acceptance by one cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (rspValid && !acceptPending) begin
        $display("Response in test %s without an accepted fetch", testName);
        errorCount++;
      end else if (acceptPending && !rspValid) begin
        $display("No response one cycle after acceptance in test %s", testName);
        errorCount++;
      end else if (rspValid && rspData !== expWord) begin
        $display("ERROR %s expected %08h actual %08h", testName, expWord, rspData);
        errorCount++;
      end
      if (rspValid) begin
        respCount++;
      end
      acceptPending = fetchValid && !stall;
      expWord = refWord(cpuAddr);
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles with a fetch or response still outstanding", cycleCount);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic fetchWord(input logic [TagBits-1:0] tag, input int index, input int word);
    fetchAddr a;
    int expReq;
    int reqBefore;
    int respBefore;
    a = {tag, IndexBits'(index), WordOffsetBits'(word), 2'b00};
    expReq = predictRequests(a);
    reqBefore = requestCount;
    respBefore = respCount;
    @(posedge clk);
    #1;
    fetchValid = 1'b1;
    cpuAddr = a;
    // Held while stalled
    do begin
      @(negedge clk);
    end while (stall);
    @(posedge clk);
    #1;
    fetchValid = 1'b0;
    wait (respCount > respBefore);
    if (requestCount - reqBefore != expReq) begin
      $display("ERROR %s requests expected %0d actual %0d", testName, expReq,
        requestCount - reqBefore);
      errorCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    errorsAtStart = errorCount + creditErrors;
    requestsAtStart = requestCount;
  endtask

  task automatic finishTest(input int expRequests);
    int failures;
    if (requestCount - requestsAtStart != expRequests) begin
      $display("ERROR %s total requests expected %0d actual %0d", testName, expRequests,
        requestCount - requestsAtStart);
      errorCount++;
    end
    failures = errorCount + creditErrors - errorsAtStart;
    testsRun++;
    if (failures == 0) begin
      $display("Test %s ok", testName);
    end else begin
      $display("Test %s had %0d errors", testName, failures);
      testsFailed++;
    end
  endtask

  initial begin
    reset = 1'b1;
    enable = 1'b1;
    fetchValid = 1'b0;
    cpuAddr = '0;
    longDelay = 1'b0;
    for (int s = 0; s < NumSets; s++) begin
      modelValid[0][s] = 1'b0;
      modelValid[1][s] = 1'b0;
      modelLru[s] = 1'b0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    startTest("cold miss");
    for (int i = 0; i < 4; i++) begin
      fetchWord(24'h100 + i, i, i);
    end
    finishTest(4);

    startTest("hit");
    for (int w = 0; w < 4; w++) begin
      fetchWord(24'h100, 0, w);
    end
    finishTest(0);

    startTest("two ways");
    fetchWord(24'ha00, 5, 0);
    fetchWord(24'hb00, 5, 1);
    for (int i = 0; i < 3; i++) begin
      fetchWord(24'ha00, 5, i);
      fetchWord(24'hb00, 5, 3 - i);
    end
    finishTest(2);

    // Way holding 0xa00 is least recent here
    startTest("lru replacement");
    fetchWord(24'hd00, 5, 2);
    fetchWord(24'hb00, 5, 0);
    fetchWord(24'ha00, 5, 1);
    finishTest(2);

    startTest("bypass");
    @(posedge clk);
    #1;
    enable = 1'b0;
    fetchWord(24'h100, 0, 1);
    fetchWord(24'hc00, 6, 2);
    fetchWord(24'hc00, 6, 2);
    @(posedge clk);
    #1;
    enable = 1'b1;
    finishTest(3);

    startTest("credit back-pressure");
    longDelay = 1'b1;
    for (int i = 8; i < NumSets; i++) begin
      fetchWord(24'he00 + i, i, i % 4);
    end
    for (int i = 8; i < NumSets; i++) begin
      fetchWord(24'he00 + i, i, 3 - i % 4);
    end
    finishTest(8);

    $display("Tests run %0d, failed %0d, errors %0d, memory requests %0d", testsRun,
      testsFailed, errorCount + creditErrors, requestCount);
    if (testsFailed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim/icacheMemModel.sv */
// Behavioural instruction memory that grants credits and returns beats after random delays
`timescale 1ns/1ps

module icacheMemModel import icachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic longDelay,
  input  logic reqValid,
  input  memReq req,
  output logic creditReturn,
  output memBeat beat,
  output int creditErrors
);

  logic [31:0] lfsr = 32'h4bfed0e4;
  int pendingGrants;
  int grantsHeld;

  // Galois LFSR, one step per bit taken
  function automatic int takeBits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic logic [31:0] wordValue(input logic [31:0] wordAddr);
    return wordAddr * 32'h9e3779b1 + wordAddr;
  endfunction

  // Credits owned by memory go back one at a time
  initial begin
    creditReturn = 1'b0;
    pendingGrants = MemCredits;
    @(negedge reset);
    forever begin
      @(posedge clk);
      if (pendingGrants > 0) begin
        repeat (takeBits(longDelay ? 4 : 2)) @(posedge clk);
        #1;
        creditReturn = 1'b1;
        pendingGrants--;
        @(posedge clk);
        #1;
        creditReturn = 1'b0;
      end
    end
  end

  // One request at a time, beats in order with gaps
  initial begin
    memReq taken;
    int beats;
    beat = '0;
    forever begin
      @(negedge clk);
      if (!reset && reqValid) begin
        taken = req;
        beats = taken.singleWord ? 1 : LineWords;
        @(posedge clk);
        for (int i = 0; i < beats; i++) begin
          repeat (takeBits(2)) @(posedge clk);
          #1;
          beat.valid = 1'b1;
          beat.data = wordValue({2'b00, taken.wordAddr} + 32'(i));
          @(posedge clk);
          #1;
          beat = '0;
        end
        pendingGrants++;
      end
    end
  end

  // Grants handed out minus requests taken, checked ahead of each edge
  always @(negedge clk) begin
    if (reset) begin
      grantsHeld = 0;
      creditErrors = 0;
    end else begin
      if (reqValid && grantsHeld == 0) begin
        $display("Request issued at the memory port without an outstanding credit grant");
        creditErrors++;
      end
      grantsHeld += (creditReturn ? 1 : 0) - (reqValid ? 1 : 0);
    end
  end

endmodule

/* design/icacheTop.sv */
// Instruction cache top connecting controller, tag store, data store and fill unit
`timescale 1ns/1ps

module icacheTop import icachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic fetchValid,
  input  icachePkg::fetchAddr fetchAddr,
  input  logic creditReturn,
  input  memBeat beat,
  output logic stall,
  output logic rspValid,
  output logic [DataBits-1:0] rspData,
  output logic reqValid,
  output memReq req
);

  tagLookup lookup;
  logic beatValid;
  logic fillDone;
  logic startFill;
  logic singleWord;
  logic way1Write;
  logic way2Write;
  logic waySel;
  logic lruUpdate;
  logic [WordOffsetBits-1:0] writeOffset;
  logic [DataBits-1:0] writeData;

  icacheController controller (
    .clk(clk), .reset(reset), .enable(enable),
    .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .lookup(lookup), .beatValid(beatValid), .fillDone(fillDone),
    .stall(stall), .rspValid(rspValid),
    .startFill(startFill), .singleWord(singleWord),
    .way1Write(way1Write), .way2Write(way2Write),
    .waySel(waySel), .lruUpdate(lruUpdate)
  );

  icacheTagStore tagStore (
    .clk(clk), .reset(reset), .addr(fetchAddr),
    .way1Write(way1Write), .way2Write(way2Write),
    .lruUpdate(lruUpdate), .hitWay(waySel), .lookup(lookup)
  );

  // Captured beat doubles as the bypass word
  icacheDataStore dataStore (
    .clk(clk), .addr(fetchAddr),
    .writeOffset(writeOffset), .writeData(writeData),
    .way1Write(way1Write), .way2Write(way2Write), .waySel(waySel),
    .bypassData(writeData), .enable(enable), .rspData(rspData)
  );

  icacheFillUnit fillUnit (
    .clk(clk), .reset(reset),
    .startFill(startFill), .singleWord(singleWord), .addr(fetchAddr),
    .creditReturn(creditReturn), .beat(beat),
    .reqValid(reqValid), .req(req), .beatValid(beatValid),
    .writeOffset(writeOffset), .writeData(writeData), .fillDone(fillDone)
  );

endmodule

/* design/icacheFillUnit.sv */
// Instruction cache fill unit with credit counting, request issue and beat capture
`timescale 1ns/1ps

module icacheFillUnit import icachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic startFill,
  input  logic singleWord,
  input  fetchAddr addr,
  input  logic creditReturn,
  input  memBeat beat,
  output logic reqValid,
  output memReq req,
  output logic beatValid,
  output logic [WordOffsetBits-1:0] writeOffset,
  output logic [DataBits-1:0] writeData,
  output logic fillDone
);

  logic [CreditBits-1:0] creditCount;
  logic [WordOffsetBits-1:0] beatCount;
  logic issued;
  logic lastBeat;

  // One request per fill, and only with a credit in hand
  assign reqValid = startFill && !issued && (creditCount != '0);

  always_comb begin
    req.singleWord = singleWord;
    if (singleWord) begin
      req.wordAddr = {addr.tag, addr.index, addr.wordOffset};
    end else begin
      req.wordAddr = {addr.tag, addr.index, {WordOffsetBits{1'b0}}};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      creditCount <= '0;
    end else if (creditReturn && !reqValid) begin
      creditCount <= creditCount + 1'b1;
    end else if (reqValid && !creditReturn) begin
      creditCount <= creditCount - 1'b1;
    end
  end

  // Cleared by the registered done so the FSM leaves MemRead first
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      issued <= 1'b0;
    end else if (reqValid) begin
      issued <= 1'b1;
    end else if (fillDone) begin
      issued <= 1'b0;
    end
  end

  assign lastBeat = singleWord || (beatCount == LineWords - 1);

  // Beats come in order from offset 0
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beatCount <= '0;
      beatValid <= 1'b0;
      fillDone <= 1'b0;
    end else begin
      beatValid <= beat.valid;
      fillDone <= beat.valid && lastBeat;
      if (beat.valid) begin
        beatCount <= lastBeat ? '0 : beatCount + 1'b1;
      end
    end
  end

  // Captured beat, also held as the bypass word
  always_ff @(posedge clk) begin
    if (beat.valid) begin
      writeOffset <= beatCount;
      writeData <= beat.data;
    end
  end

  assert property (@(posedge clk) disable iff (reset) reqValid |-> (creditCount != '0));

  // Memory never grants more than it owns
  assert property (@(posedge clk) disable iff (reset) creditCount <= MemCredits);

endmodule

/* design/icacheDataStore.sv */
// Instruction cache data store with two ways of four-word lines and a registered read
`timescale 1ns/1ps

module icacheDataStore import icachePkg::*; (
  input  logic clk,
  input  fetchAddr addr,
  input  logic [WordOffsetBits-1:0] writeOffset,
  input  logic [DataBits-1:0] writeData,
  input  logic way1Write,
  input  logic way2Write,
  input  logic waySel,
  input  logic [DataBits-1:0] bypassData,
  input  logic enable,
  output logic [DataBits-1:0] rspData
);

  logic [LineWords-1:0][DataBits-1:0] way1Lines [NumSets];
  logic [LineWords-1:0][DataBits-1:0] way2Lines [NumSets];

  logic [DataBits-1:0] way1Word;
  logic [DataBits-1:0] way2Word;

  // One word per accepted beat
  always_ff @(posedge clk) begin
    if (way1Write) begin
      way1Lines[addr.index][writeOffset] <= writeData;
    end
    if (way2Write) begin
      way2Lines[addr.index][writeOffset] <= writeData;
    end
  end

  assign way1Word = way1Lines[addr.index][addr.wordOffset];
  assign way2Word = way2Lines[addr.index][addr.wordOffset];

  // Registered read port, bypass word when the cache is off
  always_ff @(posedge clk) begin
    if (!enable) begin
      rspData <= bypassData;
    end else if (waySel) begin
      rspData <= way1Word;
    end else begin
      rspData <= way2Word;
    end
  end

endmodule

/* design/icacheTagStore.sv */
// Instruction cache tag store holding tags, valid bits and one LRU bit per set
`timescale 1ns/1ps

module icacheTagStore import icachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  fetchAddr addr,
  input  logic way1Write,
  input  logic way2Write,
  input  logic lruUpdate,
  input  logic hitWay,
  output tagLookup lookup
);

  logic [TagBits-1:0] way1Tags [NumSets];
  logic [TagBits-1:0] way2Tags [NumSets];
  logic [NumSets-1:0] way1Valid;
  logic [NumSets-1:0] way2Valid;
  logic [NumSets-1:0] lruBits;

  // Tag arrays
  always_ff @(posedge clk) begin
    if (way1Write) begin
      way1Tags[addr.index] <= addr.tag;
    end
    if (way2Write) begin
      way2Tags[addr.index] <= addr.tag;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      way1Valid <= '0;
      way2Valid <= '0;
    end else begin
      if (way1Write) begin
        way1Valid[addr.index] <= 1'b1;
      end
      if (way2Write) begin
        way2Valid[addr.index] <= 1'b1;
      end
    end
  end

  // hitWay high means way 1 served the response, so way 2 becomes the victim
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruUpdate) begin
      lruBits[addr.index] <= !hitWay;
    end
  end

  // Lookup is combinational so a miss stalls in the request cycle
  always_comb begin
    lookup.way1Valid = way1Valid[addr.index];
    lookup.way2Valid = way2Valid[addr.index];
    lookup.way1Tag = way1Tags[addr.index];
    lookup.way2Tag = way2Tags[addr.index];
    lookup.lru = lruBits[addr.index];
  end

  // A set is never filled into both ways at once
  assert property (@(posedge clk) disable iff (reset)
    (way1Write && way2Valid[addr.index]) |-> (way2Tags[addr.index] != addr.tag));

endmodule

/* design/icacheController.sv */
// Instruction cache controller with hit detection, victim choice and the fetch FSM
`timescale 1ns/1ps

module icacheController import icachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic fetchValid,
  input  icachePkg::fetchAddr fetchAddr,
  input  tagLookup lookup,
  input  logic beatValid,
  input  logic fillDone,
  output logic stall,
  output logic rspValid,
  output logic startFill,
  output logic singleWord,
  output logic way1Write,
  output logic way2Write,
  output logic waySel,
  output logic lruUpdate
);

  ctrlState state;
  ctrlState nextState;

  logic hit1;
  logic hit2;
  logic hit;
  logic victim1;
  logic fillWrite;
  logic accept;

  // Tag compare per way, raw hits also steer the victim during a fill
  assign hit1 = lookup.way1Valid && (lookup.way1Tag == fetchAddr.tag);
  assign hit2 = lookup.way2Valid && (lookup.way2Tag == fetchAddr.tag);
  assign hit = enable && (hit1 || hit2);

  // Read from way 1 on a way 1 hit, and always in bypass
  assign waySel = !enable || hit1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Ready: begin
        if (fetchValid && !hit) begin
          nextState = MemRead;
        end
      end
      MemRead: begin
        if (fillDone) begin
          nextState = NextInstr;
        end
      end
      NextInstr: nextState = Ready;
      default: nextState = Ready;
    endcase
  end

  // Held request is taken in NextInstr once the line or word is in place
  assign stall = (state == MemRead) || ((state == Ready) && fetchValid && !hit);
  assign accept = fetchValid && !stall;

  assign startFill = (state == MemRead);
  assign singleWord = !enable;

  // Response goes out with the registered read of the data store
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= accept;
    end
  end

  assign lruUpdate = accept && enable;

  // Victim is way 1 when it is the only empty way or LRU points at it,
  // and a way that already hits keeps the fill
  assign victim1 = ((((!lookup.way1Valid) && lookup.way2Valid) || lookup.lru) && !hit2) || hit1;

  // Nothing is written in bypass
  assign fillWrite = (state == MemRead) && beatValid && enable;
  assign way1Write = fillWrite && victim1;
  assign way2Write = fillWrite && !victim1;

  // Responses only follow an accept in Ready or NextInstr
  assert property (@(posedge clk) disable iff (reset) (state == MemRead) |-> !rspValid);

  assert property (@(posedge clk) disable iff (reset) !(way1Write && way2Write));

endmodule

/* design/icachePkg.sv */
// Instruction cache package with address fields, credit depth, FSM states and shared structs
package icachePkg;

  // Address split of a 32-bit byte address
  localparam int ByteOffsetBits = 2;
  localparam int WordOffsetBits = 2;
  localparam int IndexBits = 4;
  localparam int TagBits = 32 - ByteOffsetBits - WordOffsetBits - IndexBits;
  localparam int WordAddrBits = TagBits + IndexBits + WordOffsetBits;
  localparam int DataBits = 32;

  localparam int NumSets = 1 << IndexBits;
  localparam int LineWords = 1 << WordOffsetBits;

  // Request credits granted by memory
  localparam int MemCredits = 2;
  localparam int CreditBits = $clog2(MemCredits + 1);

  typedef enum logic [1:0] {
    Ready,
    MemRead,
    NextInstr
  } ctrlState;

  typedef struct packed {
    logic [TagBits-1:0] tag;
    logic [IndexBits-1:0] index;
    logic [WordOffsetBits-1:0] wordOffset;
    logic [ByteOffsetBits-1:0] byteOffset;
  } fetchAddr;

  // Word address is line aligned unless singleWord is set
  typedef struct packed {
    logic [WordAddrBits-1:0] wordAddr;
    logic singleWord;
  } memReq;

  typedef struct packed {
    logic valid;
    logic [DataBits-1:0] data;
  } memBeat;

  // LRU set means way 1 is the next victim
  typedef struct packed {
    logic way1Valid;
    logic way2Valid;
    logic [TagBits-1:0] way1Tag;
    logic [TagBits-1:0] way2Tag;
    logic lru;
  } tagLookup;

endpackage
